/* verilog.f */
source/raygen_pkg.sv
source/dir_fetch.sv
source/ray_group_store.sv
source/raygen_controller.sv
source/group_tracer.sv
source/raygen_top.sv
sim/tb_clock.sv
sim/raygen_tb.sv

/* Bender.yml */
package:
  name: raygen

sources:
  - files:
      - source/raygen_pkg.sv
      - source/dir_fetch.sv
      - source/ray_group_store.sv
      - source/raygen_controller.sv
      - source/group_tracer.sv
      - source/raygen_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/raygen_tb.sv

/* sim/raygen_tb.sv */
`default_nettype none

module raygen_tb;
    import raygen_pkg::*;

    localparam int frame_count = 4;

    // One frame per entry: number of groups and page bit.
    int   frame_groups [frame_count] = '{1, 2, 5, 7};
    logic frame_page   [frame_count] = '{1'b0, 1'b1, 1'b0, 1'b1};

    logic           clk;
    logic           globalreset;
    logic           go;
    ray_count_t     init_count;
    logic           page;
    logic           busy_out;
    cycle_count_t   cycles;
    mem_addr_t      next_addr;
    logic           nas0;
    logic           nas1;
    logic           result_valid0;
    logic           result_valid1;
    tracer_result_t result0;
    tracer_result_t result1;

    integer    seed;
    bit        monitor_on;
    int        results_seen;
    int        strobes_seen;
    int        last_group [2];
    checksum_t pending_sum [$];
    int        pending_group [$];

    tb_clock #(.period(8)) u_clock (.clk(clk));

    raygen_top dut (
        .clk(clk), .globalreset(globalreset),
        .go(go), .init_count(init_count), .page(page),
        .busy_out(busy_out), .cycles(cycles), .next_addr(next_addr),
        .nas0(nas0), .nas1(nas1),
        .result_valid0(result_valid0), .result_valid1(result_valid1),
        .result0(result0), .result1(result1)
    );

    // Sum of the three direction components of one ray.
    function automatic checksum_t ray_sum(input int index);
        comp_t i;
        i = comp_t'(index);
        return comp_t'(3 * i) + (i ^ 16'h5a5a) + ~i;
    endfunction

    function automatic checksum_t group_checksum(input int group);
        checksum_t sum;
        sum = '0;
        for (int r = 0; r < rays_per_group; r++)
        begin
            sum = sum + ray_sum(rays_per_group * group + r);
        end
        return sum;
    endfunction

    // Each ray needs about fetch_latency + 3 cycles, and a group may wait for a whole tracer run.
    function automatic int cycle_bound(input int groups);
        return groups * (rays_per_group * (fetch_latency + 3) + rays_per_group + tracer_hold + 4)
            + 8;
    endfunction

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            report_failure($sformatf("FAIL at time %0t: %s is %h, expected %h",
                                     $time, name, got, expected));
        end
    endtask

    // A result must match a pending group later in the stream than this tracer's last one.
    task automatic take_result(input int tracer, input tracer_result_t result);
        int found;
        found = -1;
        check_value($sformatf("result%0d bank bit", tracer), result.group_id[1], tracer);
        for (int n = 0; n < pending_sum.size(); n++)
        begin
            if ((found < 0) && (pending_group[n] > last_group[tracer])
                && (pending_sum[n] == result.checksum))
            begin
                found = n;
            end
        end
        if (found < 0)
        begin
            report_failure($sformatf("Tracer %0d reported checksum %h at time %0t, %s",
                                     tracer, result.checksum, $time,
                                     "which matches no pending group in stream order."));
        end
        else
        begin
            last_group[tracer] = pending_group[found];
            pending_sum.delete(found);
            pending_group.delete(found);
        end
        results_seen++;
    endtask

    always @(negedge clk)
    begin
        if (monitor_on)
        begin
            check_value("next_addr[17:15]", next_addr[17:15], {2'b11, page});
            if (nas0 || nas1)
            begin
                strobes_seen++;
            end
            if (result_valid0)
            begin
                take_result(0, result0);
            end
            if (result_valid1)
            begin
                take_result(1, result1);
            end
        end
    end

    task automatic run_frame(input int groups, input logic group_page);
        int gap;
        int waited;
        gap = $random(seed) & 7;
        repeat (gap) @(posedge clk);
        for (int k = 0; k < groups; k++)
        begin
            pending_sum.push_back(group_checksum(k));
            pending_group.push_back(k);
        end
        last_group[0] = -1;
        last_group[1] = -1;
        results_seen  = 0;
        strobes_seen  = 0;
        @(posedge clk);
        go         <= 1'b1;
        init_count <= ray_count_t'(groups);
        page       <= group_page;
        @(posedge clk);
        go <= 1'b0;
        @(negedge clk);
        check_value("cycles", cycles, 0);
        check_value("busy_out", busy_out, 1);
        waited = 0;
        while (busy_out)
        begin
            @(negedge clk);
            waited++;
            if (waited > cycle_bound(groups) + 20)
            begin
                report_failure($sformatf("Timeout: frame of %0d groups did not finish.", groups));
            end
        end
        // The last results arrive while the tracers wind down after the frame ends.
        repeat (rays_per_group + tracer_hold + 2) @(posedge clk);
        check_value("result count", results_seen, groups);
        check_value("nas0/nas1 pulses", strobes_seen, groups);
        check_value("busy_out", busy_out, 0);
        if ((cycles == '0) || (cycles > cycle_bound(groups)))
        begin
            report_failure($sformatf("Frame of %0d groups took %0d cycles, outside 1 to %0d.",
                                     groups, cycles, cycle_bound(groups)));
        end
    endtask

    initial
    begin
        seed          = 32'he465;
        globalreset   = 1'b1;
        go            = 1'b0;
        init_count    = '0;
        page          = 1'b0;
        monitor_on    = 1'b0;
        results_seen  = 0;
        strobes_seen  = 0;
        last_group[0] = -1;
        last_group[1] = -1;
        repeat (10) @(posedge clk);
        globalreset <= 1'b0;
        @(negedge clk);
        check_value("busy_out", busy_out, 0);
        check_value("nas0", nas0, 0);
        check_value("nas1", nas1, 0);
        check_value("result_valid0", result_valid0, 0);
        check_value("result_valid1", result_valid1, 0);
        check_value("cycles", cycles, 0);
        monitor_on = 1'b1;
        for (int f = 0; f < frame_count; f++)
        begin
            run_frame(frame_groups[f], frame_page[f]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* source/raygen_top.sv */
`default_nettype none

module raygen_top (
    input  wire logic                   clk,
    input  wire logic                   globalreset,
    input  wire logic                   go,
    input  wire raygen_pkg::ray_count_t init_count,
    input  wire logic                   page,
    output logic                        busy_out,
    output raygen_pkg::cycle_count_t    cycles,
    output raygen_pkg::mem_addr_t       next_addr,
    output logic                        nas0,
    output logic                        nas1,
    output logic                        result_valid0,
    output logic                        result_valid1,
    output raygen_pkg::tracer_result_t  result0,
    output raygen_pkg::tracer_result_t  result1
);
    import raygen_pkg::*;

    logic        want_dir;
    logic        dir_ready;
    logic        as;
    logic        ack;
    dir_t        fetch_dir;
    dir_t        store_dir;
    dir_t        rd_dir0;
    dir_t        rd_dir1;
    ray_index_t  addr_in;
    store_addr_t addr;
    store_addr_t rd_addr0;
    store_addr_t rd_addr1;
    group_id_t   raygroup0;
    group_id_t   raygroup1;
    logic        raygroup_valid0;
    logic        raygroup_valid1;
    logic        busy0;
    logic        busy1;

    dir_fetch u_fetch (
        .clk(clk), .globalreset(globalreset),
        .restart(go),  // Every frame restarts the ray stream at index 0.
        .want_dir(want_dir), .take(as),
        .dir_ready(dir_ready), .dir(fetch_dir), .addr_in(addr_in)
    );

    raygen_controller u_ctrl (
        .clk(clk), .globalreset(globalreset),
        .go(go), .init_count(init_count), .page(page),
        .busy_out(busy_out), .cycles(cycles), .next_addr(next_addr),
        .nas0(nas0), .nas1(nas1),
        .want_dir(want_dir), .dir_ready(dir_ready), .dir_in(fetch_dir), .addr_in(addr_in),
        .as(as), .addr(addr), .ack(ack), .dir(store_dir),
        .raygroup0(raygroup0), .raygroup1(raygroup1),
        .raygroup_valid0(raygroup_valid0), .raygroup_valid1(raygroup_valid1),
        .busy0(busy0), .busy1(busy1)
    );

    ray_group_store u_store (
        .clk(clk), .globalreset(globalreset),
        .as(as), .addr(addr), .dir(store_dir), .ack(ack),
        .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
        .rd_dir0(rd_dir0), .rd_dir1(rd_dir1)
    );

    group_tracer #(.bank(0)) u_tracer0 (
        .clk(clk), .globalreset(globalreset),
        .raygroup(raygroup0), .raygroup_valid(raygroup_valid0), .busy(busy0),
        .rd_addr(rd_addr0), .rd_dir(rd_dir0),
        .result_valid(result_valid0), .result(result0)
    );

    group_tracer #(.bank(1)) u_tracer1 (
        .clk(clk), .globalreset(globalreset),
        .raygroup(raygroup1), .raygroup_valid(raygroup_valid1), .busy(busy1),
        .rd_addr(rd_addr1), .rd_dir(rd_dir1),
        .result_valid(result_valid1), .result(result1)
    );

endmodule

`default_nettype wire

/* source/group_tracer.sv */
`default_nettype none

module group_tracer #(
    parameter int bank = 0
) (
    input  wire logic                    clk,
    input  wire logic                    globalreset,
    input  wire raygen_pkg::group_id_t   raygroup,
    input  wire logic                    raygroup_valid,
    output logic                         busy,
    output raygen_pkg::store_addr_t      rd_addr,
    input  wire raygen_pkg::dir_t        rd_dir,
    output logic                         result_valid,
    output raygen_pkg::tracer_result_t   result
);
    import raygen_pkg::*;

    logic [$clog2(rays_per_group + tracer_hold + 1) - 1:0] step;
    group_id_t                                              tag;
    checksum_t                                              sum;
    checksum_t                                              ray_sum;

    // Steps 0 to 2 read the rays, then the result goes out and busy is held.
    assign rd_addr = {1'(bank), tag[0], step[1:0]};
    assign ray_sum = rd_dir.x + rd_dir.y + rd_dir.z;
    assign result  = '{group_id: tag, checksum: sum};

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
            step         <= '0;
        end
        else
        begin
            result_valid <= 1'b0;
            if (!busy)
            begin
                if (raygroup_valid)
                begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end
            else
            begin
                step <= step + 1'b1;
                if (step == rays_per_group - 1)
                begin
                    result_valid <= 1'b1;
                end
                if (step == rays_per_group + tracer_hold)
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && raygroup_valid)
        begin
            tag <= raygroup;  // Tag and sum are only meaningful with result_valid.
            sum <= '0;
        end
        else if (busy && (step < rays_per_group))
        begin
            sum <= sum + ray_sum;
        end
    end

endmodule

`default_nettype wire

/* source/raygen_controller.sv */
`default_nettype none

module raygen_controller (
    input  wire logic                   clk,
    input  wire logic                   globalreset,
    input  wire logic                   go,
    input  wire raygen_pkg::ray_count_t init_count,
    input  wire logic                   page,
    output logic                        busy_out,
    output raygen_pkg::cycle_count_t    cycles,
    output raygen_pkg::mem_addr_t       next_addr,
    output logic                        nas0,
    output logic                        nas1,
    output logic                        want_dir,
    input  wire logic                   dir_ready,
    input  wire raygen_pkg::dir_t       dir_in,
    input  wire raygen_pkg::ray_index_t addr_in,
    output logic                        as,
    output raygen_pkg::store_addr_t     addr,
    input  wire logic                   ack,
    output raygen_pkg::dir_t            dir,
    output raygen_pkg::group_id_t       raygroup0,
    output raygen_pkg::group_id_t       raygroup1,
    output logic                        raygroup_valid0,
    output logic                        raygroup_valid1,
    input  wire logic                   busy0,
    input  wire logic                   busy1
);
    import raygen_pkg::*;

    raygen_state_t state;
    raygen_state_t n_state;
    cycle_count_t  n_cycles;
    ray_count_t    count;       // Groups still to dispatch.
    ray_count_t    n_count;
    ray_count_t    fetch_left;  // Groups still to fetch.
    ray_count_t    n_fetch_left;
    logic [1:0]    ray_num;
    logic [1:0]    n_ray_num;
    logic          active;
    logic          n_active;
    logic [1:0]    slot;
    logic [1:0]    n_slot;
    logic [1:0]    loaded;
    logic [1:0]    n_loaded;
    logic [1:0]    valid;
    logic [1:0]    n_valid;
    logic          stored;      // Group written, waiting for a bank or a tracer.
    logic          n_stored;
    logic [1:0]    busy;
    logic          take;
    logic          last_ray;
    logic          group_end;
    logic          d_bank;

    assign busy      = {busy1, busy0};
    assign take      = (state == fetch) && dir_ready;
    assign last_ray  = (ray_num == 2'(rays_per_group - 1));
    assign group_end = stored || (ack && last_ray);
    assign d_bank    = (state == dispatch1);

    assign want_dir        = (state == fetch);
    assign as              = take || ((state == write) && !stored);
    assign addr            = {active, slot[active], ray_num};
    assign busy_out        = (state != idle);
    assign next_addr       = {2'b11, page, addr_in};
    assign nas0            = take && (ray_num == '0) && !active;
    assign nas1            = take && (ray_num == '0) && active;
    assign raygroup0       = {1'b0, slot[0]};
    assign raygroup1       = {1'b1, slot[1]};
    assign raygroup_valid0 = valid[0];
    assign raygroup_valid1 = valid[1];

    always_comb
    begin
        n_state      = state;
        n_cycles     = cycles + 1'b1;
        n_count      = count;
        n_fetch_left = fetch_left;
        n_ray_num    = ray_num;
        n_active     = active;
        n_slot       = slot;
        n_loaded     = loaded;
        n_valid      = valid;
        n_stored     = stored;
        case (state)
            idle:
            begin
                n_cycles = cycles;
                if (go)
                begin
                    n_cycles     = '0;
                    n_count      = init_count;
                    n_fetch_left = init_count;
                    n_ray_num    = '0;
                    n_active     = 1'b0;
                    n_slot       = '0;
                    n_loaded     = '0;
                    n_valid      = '0;
                    n_stored     = 1'b0;
                    if (init_count != '0)
                    begin
                        n_state = fetch;
                    end
                end
            end
            fetch:
            begin
                if (dir_ready)
                begin
                    n_state = write;
                    if (last_ray)  // Bank counts as loaded once its last ray is taken.
                    begin
                        n_loaded[active] = 1'b1;
                        n_fetch_left     = fetch_left - 1'b1;
                    end
                end
            end
            write:
            begin
                if (ack && !last_ray)
                begin
                    n_ray_num = ray_num + 1'b1;
                    n_state   = fetch;
                end
                else if (group_end)
                begin
                    n_ray_num = '0;
                    n_stored  = 1'b1;
                    if (loaded[0] && !busy0)
                    begin
                        n_valid[0] = 1'b1;
                        n_stored   = 1'b0;
                        n_state    = dispatch0;
                    end
                    else if (loaded[1] && !busy1)
                    begin
                        n_valid[1] = 1'b1;
                        n_stored   = 1'b0;
                        n_state    = dispatch1;
                    end
                    else if ((loaded != 2'b11) && (fetch_left != '0))
                    begin
                        n_active = loaded[0];  // Switch to the free bank.
                        n_stored = 1'b0;
                        n_state  = fetch;
                    end
                end
            end
            dispatch0, dispatch1:
            begin
                if (busy[d_bank])
                begin
                    n_slot[d_bank]   = !slot[d_bank];
                    n_valid[d_bank]  = 1'b0;
                    n_loaded[d_bank] = 1'b0;
                    n_count          = count - 1'b1;
                    n_ray_num        = '0;
                    if (loaded[!d_bank] && !busy[!d_bank])
                    begin
                        n_valid[!d_bank] = 1'b1;
                        n_state          = d_bank ? dispatch0 : dispatch1;
                    end
                    else if (count == ray_count_t'(1))
                    begin
                        n_state = idle;
                    end
                    else if (fetch_left != '0)
                    begin
                        n_active = n_loaded[0];
                        n_state  = fetch;
                    end
                    else
                    begin
                        n_stored = 1'b1;  // Last group still waits for its tracer.
                        n_state  = write;
                    end
                end
            end
            default:
            begin
                n_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            state      <= idle;
            cycles     <= '0;
            count      <= '0;
            fetch_left <= '0;
            ray_num    <= '0;
            active     <= 1'b0;
            slot       <= '0;
            loaded     <= '0;
            valid      <= '0;
            stored     <= 1'b0;
        end
        else
        begin
            state      <= n_state;
            cycles     <= n_cycles;
            count      <= n_count;
            fetch_left <= n_fetch_left;
            ray_num    <= n_ray_num;
            active     <= n_active;
            slot       <= n_slot;
            loaded     <= n_loaded;
            valid      <= n_valid;
            stored     <= n_stored;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            dir <= dir_in;
        end
    end

endmodule

`default_nettype wire

/* source/ray_group_store.sv */
`default_nettype none

module ray_group_store (
    input  wire logic                    clk,
    input  wire logic                    globalreset,
    input  wire logic                    as,
    input  wire raygen_pkg::store_addr_t addr,
    input  wire raygen_pkg::dir_t        dir,
    output logic                         ack,
    input  wire raygen_pkg::store_addr_t rd_addr0,
    input  wire raygen_pkg::store_addr_t rd_addr1,
    output raygen_pkg::dir_t             rd_dir0,
    output raygen_pkg::dir_t             rd_dir1
);
    import raygen_pkg::*;

    dir_t        mem [2**$bits(store_addr_t)];
    store_addr_t wr_addr;

    // One-cycle ack per strobe, even if as stays high.
    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= as && !ack;
        end
    end

    // The data arrives a cycle after the strobe, so the write lands in the ack cycle.
    always_ff @(posedge clk)
    begin
        if (as)
        begin
            wr_addr <= addr;
        end
        if (ack)
        begin
            mem[wr_addr] <= dir;
        end
    end

    assign rd_dir0 = mem[rd_addr0];
    assign rd_dir1 = mem[rd_addr1];

endmodule

`default_nettype wire

/* source/dir_fetch.sv */
`default_nettype none

module dir_fetch (
    input  wire logic                   clk,
    input  wire logic                   globalreset,
    input  wire logic                   restart,
    input  wire logic                   want_dir,
    input  wire logic                   take,
    output logic                        dir_ready,
    output raygen_pkg::dir_t            dir,
    output raygen_pkg::ray_index_t      addr_in
);
    import raygen_pkg::*;

    ray_index_t                              index;
    logic [$clog2(fetch_latency + 1) - 1:0]  wait_cnt;
    logic                                    expire;
    comp_t                                   index_ext;
    dir_t                                    fresh_dir;

    assign addr_in   = index;
    assign index_ext = comp_t'(index);
    assign expire    = !dir_ready && (wait_cnt == 1);

    // Directions are a pure function of the ray index.
    assign fresh_dir.x = comp_t'(3 * index_ext);
    assign fresh_dir.y = index_ext ^ 16'h5a5a;
    assign fresh_dir.z = ~index_ext;

    always_ff @(posedge clk)
    begin
        if (globalreset || restart)
        begin
            index     <= '0;
            wait_cnt  <= '0;
            dir_ready <= 1'b0;
        end
        else if (dir_ready)
        begin
            if (take && want_dir)  // Direction consumed, move to the next ray.
            begin
                index     <= index + 1'b1;
                dir_ready <= 1'b0;
            end
        end
        else if (wait_cnt != '0)
        begin
            if (expire)
            begin
                dir_ready <= 1'b1;
                wait_cnt  <= '0;
            end
            else
            begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
        else if (want_dir)
        begin
            wait_cnt <= ($bits(wait_cnt))'(fetch_latency - 1);  // New request starts the wait.
        end
    end

    always_ff @(posedge clk)
    begin
        if (expire)
        begin
            dir <= fresh_dir;
        end
    end

endmodule

`default_nettype wire

/* source/raygen_pkg.sv */
`default_nettype none

package raygen_pkg;

    typedef logic [14:0] ray_count_t;
    typedef logic [14:0] ray_index_t;
    typedef logic [15:0] comp_t;
    typedef logic [3:0]  store_addr_t;  // {bank, slot, ray[1:0]}.
    typedef logic [1:0]  group_id_t;    // {bank, slot}.
    typedef logic [17:0] mem_addr_t;
    typedef logic [30:0] cycle_count_t;
    typedef logic [15:0] checksum_t;

    typedef struct packed {
        comp_t x;
        comp_t y;
        comp_t z;
    } dir_t;

    typedef struct packed {
        group_id_t group_id;
        checksum_t checksum;
    } tracer_result_t;

    typedef enum logic [2:0] {
        idle,
        fetch,
        write,
        dispatch0,
        dispatch1
    } raygen_state_t;

    localparam int rays_per_group = 3;
    localparam int fetch_latency  = 2;
    localparam int tracer_hold    = 4;  // Busy cycles after the result pulse.

endpackage

`default_nettype wire
